//--- logic/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// ##############################
// Memory address widths
// ##############################

`define PRG_AW      17	// 128 KB PRG, eight 16 KB banks.
`define CHR_AW      17	// 128 KB CHR, sixteen 8 KB banks.
`define SRM_AW      13	// 8 KB battery SRAM window.
`define CIRAM_AW    11	// Two 1 KB nametable pages.

// ##############################
// Save-state register map
// ##############################

`define SST_PRG     8'd0	// PRG bank register.
`define SST_CHR     8'd1	// CHR bank register.
`define SST_MIR     8'd2	// Packed mirroring bits.
`define SST_IDX     8'd127	// Mapper index, read only.

// iNES number of the mapper in this core
`define MAP_IDX     8'd78

`endif

//--- logic/nes_bus_pkg.sv
`default_nettype none
`include "cart_params.svh"

package nes_bus_pkg;

	// ##############################
	// CPU side
	// ##############################

	// One m2 cycle of the 6502 bus as seen by the cartridge
	typedef struct packed {
		logic [15:0] addr;	// CPU address.
		logic [7:0]  data;	// Write data.
		logic        rw;	// High on read.
	} cpu_bus;

	// ##############################
	// PPU side
	// ##############################

	// Both strobes are active high here,
	// unlike the real /RD and /WE pins
	typedef struct packed {
		logic [13:0] addr;	// PPU address.
		logic [7:0]  data;	// Write data.
		logic        rd;	// Read strobe.
		logic        wr;	// Write strobe.
	} ppu_bus;

	// ##############################
	// Memory control
	// ##############################

	// What a mapper hands to one of the cartridge memories.
	// The address is sized for the largest chip; smaller
	// memories take the low bits only.
	typedef struct packed {
		logic [`PRG_AW-1:0] addr;	// Byte address.
		logic               ce;	// Chip selected.
		logic               oe;	// Read enable.
		logic               we;	// Write enable.
		logic [7:0]         dati;	// Data into the chip.
	} mem_ctrl;

endpackage

`default_nettype wire

//--- logic/cart_sys_pkg.sv
`default_nettype none
`include "cart_params.svh"

package cart_sys_pkg;

	// ##############################
	// System side
	// ##############################

	typedef struct packed {
		logic       chr_ram;	// CHR is RAM, PPU may write it.
		logic [7:0] map_idx;	// iNES mapper number.
	} sys_cfg;

	// Register access used by save and restore
	typedef struct packed {
		logic       act;	// Save-state cycle in progress.
		logic       we_reg;	// Write dato into the register.
		logic [7:0] addr;	// Register number.
		logic [7:0] dato;	// Data towards the mapper.
	} sst_bus;

	// ##############################
	// Loader
	// ##############################

	typedef enum logic [1:0] {
		LD_PRG = 2'd0,
		LD_CHR = 2'd1,
		LD_SRM = 2'd2
	} load_tgt;

	typedef struct packed {
		logic               stb;	// One-cycle write strobe.
		load_tgt            tgt;	// Which memory.
		logic [`PRG_AW-1:0] addr;
		logic [7:0]         data;
	} load_wr;

	// ##############################
	// Mapper ports
	// ##############################

	typedef struct packed {
		nes_bus_pkg::cpu_bus cpu;
		nes_bus_pkg::ppu_bus ppu;
		sys_cfg              cfg;
		sst_bus              sst;
		logic [7:0]          prg_do;	// PRG read data.
		logic [7:0]          chr_do;	// CHR read data.
		logic [7:0]          srm_do;	// SRAM read data.
	} map_in;

	typedef struct packed {
		nes_bus_pkg::mem_ctrl prg;
		nes_bus_pkg::mem_ctrl chr;
		nes_bus_pkg::mem_ctrl srm;
		logic                 map_cpu_oe;	// Mapper owns the CPU data bus.
		logic [7:0]           map_cpu_do;
		logic                 map_ppu_oe;	// Mapper owns the PPU data bus.
		logic [7:0]           map_ppu_do;
		logic                 ciram_a10;	// Nametable page select.
		logic                 ciram_ce;	// Nametable RAM selected.
		logic [7:0]           sst_di;	// Register readback.
	} map_out;

endpackage

`default_nettype wire

//--- logic/mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
	parameter int AW = 11
) (
	input  wire          m2,
	input  wire [AW-1:0] addr,
	input  wire [7:0]    wdata,
	input  wire          we,
	output logic [7:0]   rdata
);

	// ##############################
	// Storage
	// ##############################

	logic [7:0] mem [2**AW];

	// Contents come from the loader or the PPU,
	// so nothing here is cleared.
	always_ff @(posedge m2)
	begin
		if (we)
		begin
			mem[addr] <= wdata;	// Write at the m2 edge.
		end
	end

	assign rdata = mem[addr];	// Combinational read.

endmodule

`default_nettype wire

//--- logic/map_078.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module map_078 (
	input  wire                  m2,
	input  wire                  rst_n,
	input  wire cart_sys_pkg::map_in mai,
	output cart_sys_pkg::map_out mao
);

	nes_bus_pkg::cpu_bus  cpu;
	nes_bus_pkg::ppu_bus  ppu;
	cart_sys_pkg::sys_cfg cfg;
	cart_sys_pkg::sst_bus sst;

	nes_bus_pkg::mem_ctrl prg;
	nes_bus_pkg::mem_ctrl chr;
	nes_bus_pkg::mem_ctrl srm;

	logic [2:0] prg_reg;
	logic [3:0] chr_reg;
	logic       mirror_mode;	// Page or H/V select.
	logic       mir;	// One-screen mode.
	logic       we_latch;	// First write seen.
	logic       cpu_wr;

	assign cpu = mai.cpu;
	assign ppu = mai.ppu;
	assign cfg = mai.cfg;
	assign sst = mai.sst;

	assign cpu_wr = !cpu.rw && cpu.addr[15];	// Any write to 0x8000-0xFFFF.

	// ##############################
	// Bank registers
	// ##############################

	always_ff @(posedge m2 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prg_reg     <= 3'd0;
			chr_reg     <= 4'd0;
			mirror_mode <= 1'b0;
			mir         <= 1'b0;
			we_latch    <= 1'b0;
		end
		else if (sst.act)
		begin
			// CPU writes are locked out for the whole sequence
			if (sst.we_reg && sst.addr == `SST_PRG)
			begin
				prg_reg <= sst.dato[2:0];
			end
			if (sst.we_reg && sst.addr == `SST_CHR)
			begin
				chr_reg <= sst.dato[3:0];
			end
			if (sst.we_reg && sst.addr == `SST_MIR)
			begin
				{mirror_mode, mir, we_latch} <= sst.dato[2:0];
			end
		end
		else if (cpu_wr)
		begin
			prg_reg     <= cpu.data[2:0];
			mirror_mode <= cpu.data[3];
			chr_reg     <= cpu.data[7:4];
			we_latch    <= 1'b1;
			if (!we_latch)
			begin
				mir <= cpu.data == 8'h03;	// Board type decided once.
			end
		end
	end

	// ##############################
	// Memory decode
	// ##############################

	always_comb
	begin
		srm.ce   = cpu.addr[15:13] == 3'b011;	// 0x6000-0x7FFF.
		srm.oe   = cpu.rw;
		srm.we   = 1'b0;	// Read only window.
		srm.addr = `PRG_AW'(cpu.addr[12:0]);
		srm.dati = cpu.data;

		prg.ce   = cpu.addr[15];
		prg.oe   = cpu.rw;
		prg.we   = 1'b0;
		prg.addr = {(cpu.addr[14] ? 3'b111 : prg_reg), cpu.addr[13:0]};	// Last bank fixed.
		prg.dati = cpu.data;

		chr.ce   = !ppu.addr[13];	// Pattern tables.
		chr.oe   = ppu.rd;
		chr.we   = cfg.chr_ram && ppu.wr && !ppu.addr[13];
		chr.addr = {chr_reg, ppu.addr[12:0]};
		chr.dati = ppu.data;
	end

	// ##############################
	// Outputs
	// ##############################

	always_comb
	begin
		mao.prg = prg;
		mao.chr = chr;
		mao.srm = srm;

		mao.map_cpu_oe = (srm.ce && srm.oe) || (prg.ce && prg.oe);
		mao.map_cpu_do = srm.ce ? mai.srm_do : mai.prg_do;

		mao.map_ppu_oe = chr.ce && chr.oe;
		mao.map_ppu_do = mai.chr_do;

		// mirror_mode high picks A10, vertical arrangement
		if (mir)
		begin
			mao.ciram_a10 = mirror_mode;
		end
		else
		begin
			mao.ciram_a10 = mirror_mode ? ppu.addr[10] : ppu.addr[11];
		end
		mao.ciram_ce = ppu.addr[13];	// 0x2000-0x3FFF.

		case (sst.addr)
			`SST_PRG: mao.sst_di = {5'd0, prg_reg};
			`SST_CHR: mao.sst_di = {4'd0, chr_reg};
			`SST_MIR: mao.sst_di = {5'd0, mirror_mode, mir, we_latch};
			`SST_IDX: mao.sst_di = cfg.map_idx;
			default:  mao.sst_di = 8'hff;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/sst_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module sst_engine (
	input  wire                  m2,
	input  wire                  rst_n,
	input  wire                  save_req,
	input  wire                  restore_req,
	input  wire [7:0]            sst_di,
	output cart_sys_pkg::sst_bus sst,
	output logic                 sst_busy,
	output logic                 sst_done
);

	logic [1:0] step;
	logic       mode;	// High while restoring.
	logic       last_step;
	logic [7:0] step_addr;
	logic [7:0] snap [4];	// One byte per register.

	// ##############################
	// Address table
	// ##############################

	always_comb
	begin
		case (step)
			2'd0:    step_addr = `SST_PRG;
			2'd1:    step_addr = `SST_CHR;
			2'd2:    step_addr = `SST_MIR;
			default: step_addr = `SST_IDX;
		endcase
	end

	assign last_step = step == 2'd3;

	// ##############################
	// Sequencer
	// ##############################

	always_ff @(posedge m2 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sst_busy <= 1'b0;
			sst_done <= 1'b0;
			step     <= 2'd0;
			mode     <= 1'b0;
		end
		else
		begin
			sst_done <= 1'b0;
			if (!sst_busy)
			begin
				if (save_req || restore_req)
				begin
					sst_busy <= 1'b1;
					mode     <= !save_req;	// Save wins a tie.
					step     <= 2'd0;
				end
			end
			else
			begin
				step <= step + 2'd1;
				if (last_step)
				begin
					sst_busy <= 1'b0;
					sst_done <= 1'b1;	// Single pulse.
				end
			end
		end
	end

	// Snapshot of the mapper state
	always_ff @(posedge m2)
	begin
		if (sst_busy && !mode)
		begin
			snap[step] <= sst_di;
		end
	end

	always_comb
	begin
		sst.act    = sst_busy;
		sst.we_reg = sst_busy && mode && !last_step;	// Index is read only.
		sst.addr   = step_addr;
		sst.dato   = snap[step];
	end

endmodule

`default_nettype wire

//--- logic/cart_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module cart_core (
	input  wire                       m2,
	input  wire                       rst_n,
	input  wire nes_bus_pkg::cpu_bus  cpu,
	output logic [7:0]                cpu_dout,
	output logic                      cpu_oe,
	input  wire nes_bus_pkg::ppu_bus  ppu,
	output logic [7:0]                ppu_dout,
	input  wire cart_sys_pkg::sys_cfg cfg,
	input  wire cart_sys_pkg::load_wr load,
	input  wire                       save_req,
	input  wire                       restore_req,
	output logic                      sst_busy,
	output logic                      sst_done
);

	cart_sys_pkg::map_in  mai;
	cart_sys_pkg::map_out mao;
	cart_sys_pkg::sst_bus sst;

	logic       ld_prg;
	logic       ld_chr;
	logic       ld_srm;
	logic [7:0] prg_do;
	logic [7:0] chr_do;
	logic [7:0] srm_do;
	logic [7:0] ciram_do;

	// ##############################
	// Loader steering
	// ##############################

	assign ld_prg = load.stb && load.tgt == cart_sys_pkg::LD_PRG;
	assign ld_chr = load.stb && load.tgt == cart_sys_pkg::LD_CHR;
	assign ld_srm = load.stb && load.tgt == cart_sys_pkg::LD_SRM;

	// ##############################
	// Mapper and save state
	// ##############################

	always_comb
	begin
		mai.cpu         = cpu;
		mai.ppu         = ppu;
		mai.cfg.chr_ram = cfg.chr_ram;
		// Unset index reports the built-in mapper
		mai.cfg.map_idx = (cfg.map_idx == 8'd0) ? `MAP_IDX : cfg.map_idx;
		mai.sst         = sst;
		mai.prg_do      = prg_do;
		mai.chr_do      = chr_do;
		mai.srm_do      = srm_do;
	end

	map_078 u_map (
		.m2    (m2),
		.rst_n (rst_n),
		.mai   (mai),
		.mao   (mao)
	);

	sst_engine u_sst (
		.m2          (m2),
		.rst_n       (rst_n),
		.save_req    (save_req),
		.restore_req (restore_req),
		.sst_di      (mao.sst_di),
		.sst         (sst),
		.sst_busy    (sst_busy),
		.sst_done    (sst_done)
	);

	// ##############################
	// Memories
	// ##############################

	mem_bank #(.AW(`PRG_AW)) prg_mem (
		.m2    (m2),
		.addr  (ld_prg ? load.addr : mao.prg.addr),
		.wdata (ld_prg ? load.data : mao.prg.dati),
		.we    (ld_prg || (mao.prg.ce && mao.prg.we)),
		.rdata (prg_do)
	);

	mem_bank #(.AW(`CHR_AW)) chr_mem (
		.m2    (m2),
		.addr  (ld_chr ? load.addr : mao.chr.addr),
		.wdata (ld_chr ? load.data : mao.chr.dati),
		.we    (ld_chr || mao.chr.we),	// PPU writes only with CHR RAM.
		.rdata (chr_do)
	);

	mem_bank #(.AW(`SRM_AW)) srm_mem (
		.m2    (m2),
		.addr  (ld_srm ? load.addr[`SRM_AW-1:0] : mao.srm.addr[`SRM_AW-1:0]),
		.wdata (ld_srm ? load.data : mao.srm.dati),
		.we    (ld_srm || (mao.srm.ce && mao.srm.we)),
		.rdata (srm_do)
	);

	// Page bit from the mapper, offset from the PPU
	mem_bank #(.AW(`CIRAM_AW)) ciram_mem (
		.m2    (m2),
		.addr  ({mao.ciram_a10, ppu.addr[9:0]}),
		.wdata (ppu.data),
		.we    (mao.ciram_ce && ppu.wr),
		.rdata (ciram_do)
	);

	// ##############################
	// Data buses
	// ##############################

	assign cpu_oe   = mao.map_cpu_oe;
	assign cpu_dout = mao.map_cpu_oe ? mao.map_cpu_do : 8'hff;	// Open bus reads high.

	always_comb
	begin
		if (mao.ciram_ce)
		begin
			ppu_dout = ciram_do;	// Nametables.
		end
		else if (mao.map_ppu_oe)
		begin
			ppu_dout = mao.map_ppu_do;
		end
		else
		begin
			ppu_dout = 8'hff;
		end
	end

endmodule

`default_nettype wire

//--- dv/cart_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cart_params.svh"

module cart_core_tb;

	localparam int load_cycles = 2**`PRG_AW + 2**`CHR_AW + 2**`SRM_AW + 2;
	localparam int test_cycles = 2000;
	localparam nes_bus_pkg::cpu_bus cpu_idle = '{addr: 16'h0000, data: 8'h00, rw: 1'b1};
	localparam nes_bus_pkg::ppu_bus ppu_idle = '{addr: 14'h0000, data: 8'h00, rd: 1'b0, wr: 1'b0};

	logic                 m2;
	logic                 rst_n;
	nes_bus_pkg::cpu_bus  cpu;
	logic [7:0]           cpu_dout;
	logic                 cpu_oe;
	nes_bus_pkg::ppu_bus  ppu;
	logic [7:0]           ppu_dout;
	cart_sys_pkg::sys_cfg cfg;
	cart_sys_pkg::load_wr load;
	logic                 save_req;
	logic                 restore_req;
	logic                 sst_busy;
	logic                 sst_done;

	logic [31:0] rng;
	logic [2:0]  model_prg;	// Expected mapper registers.
	logic [3:0]  model_chr;
	logic        model_mm;
	logic        model_mir;
	logic        model_latch;
	logic [7:0]  nt_model [2048];	// Nametable bytes written so far.

	cart_core cart_core_i (
		.m2          (m2),
		.rst_n       (rst_n),
		.cpu         (cpu),
		.cpu_dout    (cpu_dout),
		.cpu_oe      (cpu_oe),
		.ppu         (ppu),
		.ppu_dout    (ppu_dout),
		.cfg         (cfg),
		.load        (load),
		.save_req    (save_req),
		.restore_req (restore_req),
		.sst_busy    (sst_busy),
		.sst_done    (sst_done)
	);

	initial
	begin
		m2 = 1'b0;
		forever #10 m2 = !m2;	// 20 ns period.
	end

	initial
	begin
		#(2 * (load_cycles + test_cycles) * 20);
		$display("Timeout: the run did not finish within %0t", $time);
		$display("Test failed");
		$fatal(1);
	end

	// ##############################
	// Reference model
	// ##############################

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Memory contents as a function of the whole address
	function automatic logic [7:0] mem_hash(input logic [1:0] target, input logic [16:0] addr);
		logic [31:0] h;
		h = ({15'd0, addr} + {10'd0, target, 20'd0}) * 32'h9e3779b1;
		h = h ^ (h >> 15);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 13);
		return h[7:0];
	endfunction

	function automatic logic nt_page(input logic [13:0] addr);
		if (model_mir)
		begin
			return model_mm;	// One screen.
		end
		return model_mm ? addr[10] : addr[11];
	endfunction

	task automatic model_reset();
		model_prg   = 3'd0;
		model_chr   = 4'd0;
		model_mm    = 1'b0;
		model_mir   = 1'b0;
		model_latch = 1'b0;
	endtask

	task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else
		begin
			$display("error at %0t: %s expected %02h got %02h", $time, name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// ##############################
	// Bus drivers
	// ##############################

	task automatic apply_reset();
		@(posedge m2);
		rst_n <= 1'b0;
		repeat (16) @(posedge m2);
		rst_n <= 1'b1;
	endtask

	task automatic load_region(input cart_sys_pkg::load_tgt target, input int count);
		for (int a = 0; a < count; a++)
		begin
			@(posedge m2);
			load <= '{stb: 1'b1, tgt: target, addr: 17'(a), data: mem_hash(target, 17'(a))};
		end
		@(posedge m2);
		load <= '0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge m2);
		cpu <= '{addr: addr, data: data, rw: 1'b0};
		@(posedge m2);
		cpu <= cpu_idle;
		model_prg = data[2:0];
		model_mm  = data[3];
		model_chr = data[7:4];
		if (!model_latch)
		begin
			model_mir = data == 8'h03;
		end
		model_latch = 1'b1;
	endtask

	task automatic cpu_read_check(input logic [15:0] addr, input logic oe, input logic [7:0] exp);
		@(posedge m2);
		cpu <= '{addr: addr, data: 8'h00, rw: 1'b1};
		@(negedge m2);
		expect_value("cpu_oe", 8'(oe), 8'(cpu_oe));
		if (oe)
		begin
			expect_value("cpu_dout", exp, cpu_dout);
		end
	endtask

	task automatic ppu_write(input logic [13:0] addr, input logic [7:0] data);
		@(posedge m2);
		ppu <= '{addr: addr, data: data, rd: 1'b0, wr: 1'b1};
		@(posedge m2);
		ppu <= ppu_idle;
		nt_model[{nt_page(addr), addr[9:0]}] = data;
	endtask

	task automatic ppu_read_check(input logic [13:0] addr, input logic [7:0] exp);
		@(posedge m2);
		ppu <= '{addr: addr, data: 8'h00, rd: 1'b1, wr: 1'b0};
		@(negedge m2);
		expect_value("ppu_dout", exp, ppu_dout);
	endtask

	// ##############################
	// Checks
	// ##############################

	task automatic check_banks();
		logic [31:0] r;
		for (int i = 0; i < 6; i++)
		begin
			r = next_random();
			cpu_read_check({2'b10, r[13:0]}, 1'b1, mem_hash(2'd0, {model_prg, r[13:0]}));
			r = next_random();
			ppu_read_check({1'b0, r[12:0]}, mem_hash(2'd1, {model_chr, r[12:0]}));
		end
		for (int i = 0; i < 3; i++)
		begin
			r = next_random();
			cpu_read_check({2'b11, r[13:0]}, 1'b1, mem_hash(2'd0, {3'd7, r[13:0]}));	// Fixed bank.
			cpu_read_check({3'b011, r[28:16]}, 1'b1, mem_hash(2'd2, {4'd0, r[28:16]}));
		end
		r = next_random();
		cpu_read_check({1'b0, (r[14:13] == 2'b11) ? 2'b10 : r[14:13], r[12:0]}, 1'b0, 8'h00);
	endtask

	// Two bytes on opposite pages, then read all four nametables
	task automatic nt_check();
		logic [31:0] r;
		logic [13:0] a;
		r = next_random();
		ppu_write({4'h8, r[9:0]}, r[23:16]);
		ppu_write({4'hb, r[9:0]}, ~r[23:16]);
		for (int nt = 0; nt < 4; nt++)
		begin
			a = {2'b10, 2'(nt), r[9:0]};
			ppu_read_check(a, nt_model[{nt_page(a), a[9:0]}]);
		end
	endtask

	// Runs one save or restore and checks its exact timing
	task automatic sst_run(input logic restore);
		logic [7:0] ignored;
		ignored = {~model_chr, ~model_mm, ~model_prg};
		@(posedge m2);
		save_req    <= !restore;
		restore_req <= restore;
		for (int k = 0; k < 7; k++)
		begin
			@(negedge m2);
			expect_value("sst_busy", 8'(k >= 1 && k <= 4), 8'(sst_busy));
			expect_value("sst_done", 8'(k == 5), 8'(sst_done));
			@(posedge m2);
			save_req    <= (k == 2) && !restore;	// Repeat while busy.
			restore_req <= (k == 2) && restore;
			if (k == 1)
			begin
				cpu <= '{addr: 16'h8000, data: ignored, rw: 1'b0};
			end
			else
			begin
				cpu <= cpu_idle;
			end
		end
	endtask

	// ##############################
	// Test sequence
	// ##############################

	initial
	begin
		logic [31:0] r;
		logic [2:0]  saved_prg;
		logic [3:0]  saved_chr;
		logic        saved_mm;

		rst_n       = 1'b0;
		cpu         = cpu_idle;
		ppu         = ppu_idle;
		cfg         = '{chr_ram: 1'b0, map_idx: `MAP_IDX};
		load        = '0;
		save_req    = 1'b0;
		restore_req = 1'b0;
		rng         = 32'hf354;

		apply_reset();
		model_reset();
		load_region(cart_sys_pkg::LD_PRG, 2**`PRG_AW);
		load_region(cart_sys_pkg::LD_CHR, 2**`CHR_AW);
		load_region(cart_sys_pkg::LD_SRM, 2**`SRM_AW);
		check_banks();

		r = next_random();
		cpu_write({1'b1, r[14:0]}, (r[23:16] == 8'h03) ? 8'h13 : r[23:16]);	// Not one-screen.
		for (int i = 0; i < 24; i++)
		begin
			r = next_random();
			cpu_write({1'b1, r[14:0]}, r[23:16]);
			check_banks();
		end

		for (int i = 0; i < 8; i++)
		begin
			r = next_random();
			cpu_write({1'b1, r[14:0]}, {r[23:20], 1'(i), r[18:16]});
			nt_check();
		end

		saved_prg = model_prg;
		saved_chr = model_chr;
		saved_mm  = model_mm;
		sst_run(1'b0);
		check_banks();	// CPU write during the save was dropped.
		cpu_write(16'hc000, {~saved_chr, ~saved_mm, ~saved_prg});
		check_banks();
		sst_run(1'b1);
		model_prg = saved_prg;
		model_chr = saved_chr;
		model_mm  = saved_mm;
		check_banks();
		nt_check();

		apply_reset();
		model_reset();
		cpu_write(16'h8000, 8'h03);
		check_banks();
		repeat (3) nt_check();
		r = next_random();
		cpu_write({1'b1, r[14:0]}, {r[23:20], 1'b1, r[18:16]});
		repeat (3) nt_check();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- cart_core.f
+incdir+logic
logic/nes_bus_pkg.sv
logic/cart_sys_pkg.sv
logic/mem_bank.sv
logic/map_078.sv
logic/sst_engine.sv
logic/cart_core.sv
dv/cart_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f cart_core.f \
	--top-module cart_core_tb -o cart_core_sim

./obj_dir/cart_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
